//--- common/ibufPkg.sv
package ibufPkg;

    ////////////////////
    // field widths
    ////////////////////
    localparam int REG_W  = 5;
    localparam int NUM_REGS = 2 ** REG_W;

    // architectural register number
    typedef logic [REG_W-1:0] regIdT;
    typedef logic [3:0]       opcodeT;
    typedef logic [15:0]      immT;
    // 3 bits covers up to 8 warps
    typedef logic [2:0]       warpIdT;
    // opaque sequence label
    typedef logic [7:0]       tagT;

    ////////////////////
    // bundles
    ////////////////////
    typedef struct packed {
        warpIdT warpId;
        regIdT  src1;
        regIdT  src2;
        regIdT  dst;
        logic   src1Valid;
        logic   src2Valid;
        logic   dstValid;
        opcodeT opcode;
        immT    imm;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        tagT    tag;
    } decInstrT;

    // writeback from execution, clears one pending register
    typedef struct packed {
        logic   valid;
        warpIdT warpId;
        regIdT  regId;
    } wbT;

    // whether the rotation pointer moved last cycle
    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_GRANT = 1'b1
    } arbStateT;

endpackage

//--- hdl/instrIngress.sv
`timescale 1ns/1ps

module instrIngress #(
    parameter int NUM_WARPS = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  ibufPkg::decInstrT    inInstr,
    input  logic [NUM_WARPS-1:0] pop,
    output logic [NUM_WARPS-1:0] pushValid,
    output ibufPkg::decInstrT    pushInstr,
    output logic [NUM_WARPS-1:0] fetchCredit
);
    import ibufPkg::*;

    logic     validQ;
    decInstrT instrQ;

    ////////////////////
    // input register
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            instrQ <= inInstr;
        end
    end

    // steer to the owning warp
    always_comb begin
        pushValid = '0;
        if (validQ) begin
            pushValid[instrQ.warpId] = 1'b1;
        end
    end

    assign pushInstr = instrQ;

    // one credit back per freed slot, a cycle after the pop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchCredit <= '0;
        end else begin
            fetchCredit <= pop;
        end
    end

endmodule

//--- ibuffer/warpBuffer.sv
`timescale 1ns/1ps

module warpBuffer #(
    parameter int IBUF_DEPTH = 2,
    parameter int WARP_INDEX = 0
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              pushValid,
    input  ibufPkg::decInstrT pushInstr,
    input  logic              pop,
    input  ibufPkg::wbT       wb,
    output logic              ready,
    output ibufPkg::decInstrT headInstr
);
    import ibufPkg::*;

    localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(IBUF_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptrT;

    decInstrT             mem [IBUF_DEPTH];
    ptrT                  wrPtr;
    ptrT                  rdPtr;
    logic [CNT_W-1:0]     count;
    logic [NUM_REGS-1:0]  pending;
    logic                 wbHit;
    logic                 srcBlocked;
    logic                 dstBlocked;

    function automatic ptrT incPtr(ptrT p);
        incPtr = (p == ptrT'(IBUF_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    ////////////////////
    // FIFO
    ////////////////////
    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushInstr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= incPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= incPtr(rdPtr);
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign headInstr = mem[rdPtr];

    ////////////////////
    // scoreboard
    ////////////////////
    assign wbHit = wb.valid && (wb.warpId == warpIdT'(WARP_INDEX));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pending <= '0;
        end else begin
            if (wbHit) begin
                pending[wb.regId] <= 1'b0;
            end
            // issuing head claims its destination
            if (pop && headInstr.dstValid) begin
                pending[headInstr.dst] <= 1'b1;
            end
        end
    end

    // RAW on either source, WAW on destination
    assign srcBlocked = (headInstr.src1Valid && pending[headInstr.src1]) ||
                        (headInstr.src2Valid && pending[headInstr.src2]);
    assign dstBlocked = headInstr.dstValid && pending[headInstr.dst];

    assign ready = (count != '0) && !srcBlocked && !dstBlocked;

endmodule

//--- ibuffer/issueArbiter.sv
`timescale 1ns/1ps

module issueArbiter #(
    parameter int NUM_WARPS = 8
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [NUM_WARPS-1:0] ready,
    input  logic                 hasCredit,
    output logic [NUM_WARPS-1:0] grant,
    output logic                 issueValid,
    output ibufPkg::warpIdT      grantWarp
);
    import ibufPkg::*;

    arbStateT state;
    warpIdT   lastWarp;
    warpIdT   basePtr;
    warpIdT   startPtr;

    // first warp to look at this cycle
    assign startPtr = (state == ARB_GRANT) ?
                      ((lastWarp == warpIdT'(NUM_WARPS - 1)) ? '0 : lastWarp + 1'b1) :
                      basePtr;

    ////////////////////
    // rotating search
    ////////////////////
    always_comb begin
        int idx;
        logic found;
        grant = '0;
        grantWarp = '0;
        found = 1'b0;
        idx = 0;
        for (int k = 0; k < NUM_WARPS; k++) begin
            idx = (int'(startPtr) + k) % NUM_WARPS;
            if (!found && hasCredit && ready[idx]) begin
                found = 1'b1;
                grant[idx] = 1'b1;
                grantWarp = warpIdT'(idx);
            end
        end
    end

    assign issueValid = |grant;

    // pointer moves only when something was granted
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= ARB_IDLE;
            lastWarp <= '0;
            basePtr  <= '0;
        end else begin
            basePtr <= startPtr;
            if (issueValid) begin
                state    <= ARB_GRANT;
                lastWarp <= grantWarp;
            end else begin
                state <= ARB_IDLE;
            end
        end
    end

endmodule

//--- hdl/ocEgress.sv
`timescale 1ns/1ps

module ocEgress #(
    parameter int OC_CREDITS = 4
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              issueValid,
    input  ibufPkg::decInstrT issueInstr,
    input  logic              ocCredit,
    output logic              hasCredit,
    output logic              outValid,
    output ibufPkg::decInstrT outInstr
);

    localparam int CNT_W = $clog2(OC_CREDITS + 1);

    logic [CNT_W-1:0] creditCnt;

    ////////////////////
    // collector slot credits
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= CNT_W'(OC_CREDITS);
        end else begin
            // issue and return in one cycle cancel out
            case ({issueValid, ocCredit})
                2'b10:   creditCnt <= creditCnt - 1'b1;
                2'b01:   creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    assign hasCredit = (creditCnt != '0);

    ////////////////////
    // output register
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            outInstr <= issueInstr;
        end
    end

endmodule

//--- hdl/warpIssueTop.sv
`timescale 1ns/1ps

// NUM_WARPS must stay at or below 8, warp ids are 3 bits wide
module warpIssueTop #(
    parameter int NUM_WARPS  = 8,
    parameter int IBUF_DEPTH = 2,
    parameter int OC_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  ibufPkg::decInstrT    inInstr,
    output logic [NUM_WARPS-1:0] fetchCredit,
    input  ibufPkg::wbT          wb,
    output logic                 outValid,
    output ibufPkg::decInstrT    outInstr,
    input  logic                 ocCredit
);
    import ibufPkg::*;

    logic [NUM_WARPS-1:0] pushValid;
    decInstrT             pushInstr;
    logic [NUM_WARPS-1:0] ready;
    logic [NUM_WARPS-1:0] grant;
    decInstrT             heads [NUM_WARPS];
    warpIdT               grantWarp;
    logic                 issueValid;
    logic                 hasCredit;

    instrIngress #(
        .NUM_WARPS(NUM_WARPS)
    ) u_instrIngress (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inInstr(inInstr),
        .pop(grant),
        .pushValid(pushValid),
        .pushInstr(pushInstr),
        .fetchCredit(fetchCredit)
    );

    ////////////////////
    // per-warp buffers
    ////////////////////
    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_warp
        warpBuffer #(
            .IBUF_DEPTH(IBUF_DEPTH),
            .WARP_INDEX(i)
        ) u_warpBuffer (
            .clk(clk),
            .rstN(rstN),
            .pushValid(pushValid[i]),
            .pushInstr(pushInstr),
            .pop(grant[i]),
            .wb(wb),
            .ready(ready[i]),
            .headInstr(heads[i])
        );
    end

    issueArbiter #(
        .NUM_WARPS(NUM_WARPS)
    ) u_issueArbiter (
        .clk(clk),
        .rstN(rstN),
        .ready(ready),
        .hasCredit(hasCredit),
        .grant(grant),
        .issueValid(issueValid),
        .grantWarp(grantWarp)
    );

    // granted head goes to the collector side
    ocEgress #(
        .OC_CREDITS(OC_CREDITS)
    ) u_ocEgress (
        .clk(clk),
        .rstN(rstN),
        .issueValid(issueValid),
        .issueInstr(heads[grantWarp]),
        .ocCredit(ocCredit),
        .hasCredit(hasCredit),
        .outValid(outValid),
        .outInstr(outInstr)
    );

endmodule

//--- tb/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // half period high, half low
    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- tb/warpIssueTb.sv
`timescale 1ns/1ps

module warpIssueTb;
    import ibufPkg::*;

    localparam int NUM_WARPS      = 8;
    localparam int IBUF_DEPTH     = 2;
    localparam int OC_CREDITS     = 4;
    localparam int NUM_ENTRIES    = 24;
    localparam int RESET_CYCLES   = 8;
    localparam int HOLD_DELAY     = 30;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 200;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    decInstrT             inInstr;
    logic [NUM_WARPS-1:0] fetchCredit;
    wbT                   wb;
    logic                 outValid;
    decInstrT             outInstr;
    logic                 ocCredit;

    // each stimulus entry doubles as the expected output
    decInstrT stimTab    [NUM_ENTRIES];
    int       wbDelayTab [NUM_ENTRIES];
    bit       holdTab    [NUM_ENTRIES];

    int     fetchModel [NUM_WARPS];
    int     issuedCnt  [NUM_WARPS];
    int     fetchCnt   [NUM_WARPS];
    bit     pendModel  [NUM_WARPS][32];
    int     ocDueQ[$];
    int     wbDueQ[$];
    int     wbIdxQ[$];
    int     lastOcDue;
    int     outstanding;
    int     maxOutstanding;
    int     overlapIssued;
    int     nextEntry;
    int     doneCount;
    int     cycle;
    int     errors;
    int     checks;
    integer seed;

    tbClock #(.PERIOD_NS(40)) u_tbClock (.clk(clk));

    warpIssueTop u_warpIssueTop (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inInstr(inInstr),
        .fetchCredit(fetchCredit),
        .wb(wb),
        .outValid(outValid),
        .outInstr(outInstr),
        .ocCredit(ocCredit)
    );

    task automatic addEntry(input int idx, input int warp, input int s1, input bit s1v,
                            input int s2, input bit s2v, input int dst, input bit dv,
                            input int op, input int imm, input bit rw, input bit mr,
                            input bit mw, input int wbDelay, input bit hold);
        decInstrT e;
        e.warpId    = warpIdT'(warp);
        e.src1      = regIdT'(s1);
        e.src2      = regIdT'(s2);
        e.dst       = regIdT'(dst);
        e.src1Valid = s1v;
        e.src2Valid = s2v;
        e.dstValid  = dv;
        e.opcode    = opcodeT'(op);
        e.imm       = immT'(imm);
        e.regWrite  = rw;
        e.memRead   = mr;
        e.memWrite  = mw;
        e.tag       = tagT'(8'h20 + idx);
        stimTab[idx]    = e;
        wbDelayTab[idx] = wbDelay;
        holdTab[idx]    = hold;
    endtask

    // table index of the n-th entry that belongs to a warp
    function automatic int nthOfWarp(int warp, int n);
        int seen;
        nthOfWarp = -1;
        seen = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (int'(stimTab[i].warpId) == warp) begin
                if (seen == n && nthOfWarp < 0) begin
                    nthOfWarp = i;
                end
                seen++;
            end
        end
    endfunction

    // any destination of this warp still waiting on its writeback
    function automatic bit warpHasPending(int w);
        warpHasPending = 1'b0;
        for (int r = 0; r < 32; r++) begin
            if (pendModel[w][r]) begin
                warpHasPending = 1'b1;
            end
        end
    endfunction

    task automatic checkIdle();
        checks++;
        if (outValid !== 1'b0) begin
            errors++;
            $display("Fail at %0t: outValid expected 0 got %b", $time, outValid);
        end
        checks++;
        if (fetchCredit !== '0) begin
            errors++;
            $display("Fail at %0t: fetchCredit expected 0 got %b", $time, fetchCredit);
        end
    endtask

    task automatic checkHazard(int w, int k, int r);
        checks++;
        if (pendModel[w][r]) begin
            errors++;
            $display("At %0t warp %0d tag %0h was issued before the writeback of r%0d",
                     $time, w, stimTab[k].tag, r);
        end
    endtask

    ////////////////////
    // output monitor
    ////////////////////
    task automatic checkOutputs();
        int       w;
        int       k;
        int       due;
        bit       otherBusy;
        decInstrT e;
        if (outValid === 1'b1) begin
            w = int'(outInstr.warpId);
            k = nthOfWarp(w, issuedCnt[w]);
            checks++;
            if (k < 0) begin
                errors++;
                $display("At %0t warp %0d issued more instructions than it was sent", $time, w);
            end else begin
                e = stimTab[k];
                if (outInstr.tag !== e.tag) begin
                    errors++;
                    $display("Fail at %0t: outInstr.tag expected %h got %h",
                             $time, e.tag, outInstr.tag);
                end
                checks++;
                if (outInstr !== e) begin
                    errors++;
                    $display("Fail at %0t: outInstr expected %h got %h", $time, e, outInstr);
                end
                // other warps waiting on a writeback must not stall this one
                otherBusy = 1'b0;
                for (int v = 0; v < NUM_WARPS; v++) begin
                    if (v != w && warpHasPending(v)) begin
                        otherBusy = 1'b1;
                    end
                end
                if (otherBusy) begin
                    overlapIssued++;
                end
                // sources and destination must not wait on a writeback
                if (e.src1Valid) begin
                    checkHazard(w, k, int'(e.src1));
                end
                if (e.src2Valid) begin
                    checkHazard(w, k, int'(e.src2));
                end
                if (e.dstValid) begin
                    checkHazard(w, k, int'(e.dst));
                    pendModel[w][e.dst] = 1'b1;
                    wbDueQ.push_back(cycle + wbDelayTab[k]);
                    wbIdxQ.push_back(k);
                end
                issuedCnt[w]++;
                doneCount++;
            end
            outstanding++;
            if (outstanding > maxOutstanding) begin
                maxOutstanding = outstanding;
            end
            checks++;
            if (outstanding > OC_CREDITS) begin
                errors++;
                $display("Fail at %0t: outstanding outputs expected <= %0d got %0d",
                         $time, OC_CREDITS, outstanding);
            end
            // held entries keep their collector slot for a long time
            if (k >= 0 && holdTab[k]) begin
                due = cycle + HOLD_DELAY;
            end else begin
                due = cycle + 1 + ({$random(seed)} % 4);
            end
            if (due <= lastOcDue) begin
                due = lastOcDue + 1;
            end
            lastOcDue = due;
            ocDueQ.push_back(due);
        end
        for (int i = 0; i < NUM_WARPS; i++) begin
            if (fetchCredit[i] === 1'b1) begin
                fetchCnt[i]++;
                fetchModel[i]++;
                checks++;
                if (fetchModel[i] > IBUF_DEPTH) begin
                    errors++;
                    $display("Fail at %0t: fetch credit of warp %0d expected <= %0d got %0d",
                             $time, i, IBUF_DEPTH, fetchModel[i]);
                end
            end
        end
    endtask

    task automatic driveOcCredit();
        ocCredit = 1'b0;
        if (ocDueQ.size() > 0 && ocDueQ[0] <= cycle) begin
            void'(ocDueQ.pop_front());
            ocCredit = 1'b1;
            outstanding--;
        end
    endtask

    // at most one writeback per cycle with the oldest due first
    task automatic driveWriteback();
        int sel;
        int k;
        sel = -1;
        for (int i = 0; i < wbDueQ.size(); i++) begin
            if (sel < 0 && wbDueQ[i] <= cycle) begin
                sel = i;
            end
        end
        wb = '0;
        if (sel >= 0) begin
            k = wbIdxQ[sel];
            wb.valid  = 1'b1;
            wb.warpId = stimTab[k].warpId;
            wb.regId  = stimTab[k].dst;
            pendModel[int'(stimTab[k].warpId)][stimTab[k].dst] = 1'b0;
            wbDueQ.delete(sel);
            wbIdxQ.delete(sel);
        end
    endtask

    task automatic driveFetch();
        int w;
        inValid = 1'b0;
        if (nextEntry < NUM_ENTRIES) begin
            w = int'(stimTab[nextEntry].warpId);
            if (fetchModel[w] > 0) begin
                inValid = 1'b1;
                inInstr = stimTab[nextEntry];
                fetchModel[w]--;
                nextEntry++;
            end
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        cycle++;
        checkOutputs();
        driveOcCredit();
        driveWriteback();
        driveFetch();
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        seed           = 32'h2a2c;
        rstN           = 1'b0;
        inValid        = 1'b0;
        inInstr        = '0;
        wb             = '0;
        ocCredit       = 1'b0;
        lastOcDue      = 0;
        outstanding    = 0;
        maxOutstanding = 0;
        overlapIssued  = 0;
        nextEntry      = 0;
        doneCount      = 0;
        cycle          = 0;
        errors         = 0;
        checks         = 0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            fetchModel[w] = IBUF_DEPTH;
            issuedCnt[w]  = 0;
            fetchCnt[w]   = 0;
            for (int r = 0; r < 32; r++) begin
                pendModel[w][r] = 1'b0;
            end
        end

        // idx warp src1 v src2 v dst v op imm rw mr mw wbDelay hold
        addEntry(0, 0, 2, 1, 3, 1, 1, 1, 1, 16'h0011, 1, 0, 0, 8, 0);
        addEntry(1, 0, 1, 1, 4, 1, 5, 1, 2, 16'h0102, 1, 0, 0, 2, 0);
        addEntry(2, 1, 6, 1, 0, 0, 1, 1, 3, 16'h0203, 1, 0, 0, 3, 0);
        addEntry(3, 2, 7, 1, 8, 1, 9, 1, 1, 16'h0304, 1, 0, 0, 12, 0);
        addEntry(4, 2, 3, 1, 0, 0, 9, 1, 4, 16'h0405, 1, 0, 0, 1, 0);
        addEntry(5, 3, 10, 1, 11, 1, 0, 0, 9, 16'h0506, 0, 0, 1, 0, 0);
        addEntry(6, 1, 1, 1, 2, 1, 12, 1, 2, 16'h0607, 1, 0, 0, 5, 0);
        addEntry(7, 4, 13, 1, 0, 0, 14, 1, 8, 16'h0708, 1, 1, 0, 4, 0);
        addEntry(8, 5, 15, 1, 16, 1, 17, 1, 1, 16'h0809, 1, 0, 0, 2, 0);
        addEntry(9, 0, 5, 1, 5, 1, 18, 1, 3, 16'h090a, 1, 0, 0, 3, 0);
        // credit return withheld for this stretch
        addEntry(10, 3, 20, 1, 21, 1, 22, 1, 1, 16'h1000, 1, 0, 0, 2, 1);
        addEntry(11, 4, 23, 1, 0, 0, 24, 1, 2, 16'h1101, 1, 0, 0, 2, 1);
        addEntry(12, 5, 25, 1, 26, 1, 27, 1, 3, 16'h1202, 1, 0, 0, 2, 1);
        addEntry(13, 6, 28, 1, 29, 1, 30, 1, 1, 16'h1303, 1, 0, 0, 2, 1);
        addEntry(14, 7, 2, 1, 3, 1, 4, 1, 4, 16'h1404, 1, 0, 0, 2, 1);
        addEntry(15, 6, 1, 1, 0, 0, 0, 0, 9, 16'h1505, 0, 0, 1, 0, 1);
        addEntry(16, 7, 4, 1, 0, 0, 6, 1, 2, 16'h1606, 1, 0, 0, 3, 0);
        addEntry(17, 1, 12, 1, 0, 0, 12, 1, 1, 16'h1707, 1, 0, 0, 2, 0);
        addEntry(18, 2, 9, 1, 9, 1, 10, 1, 3, 16'h1808, 1, 0, 0, 4, 0);
        addEntry(19, 5, 31, 1, 0, 0, 0, 1, 8, 16'h1909, 1, 1, 0, 6, 0);
        addEntry(20, 0, 18, 1, 1, 1, 1, 1, 4, 16'h200a, 1, 0, 0, 2, 0);
        addEntry(21, 4, 14, 1, 24, 1, 11, 1, 2, 16'h210b, 1, 0, 0, 1, 0);
        addEntry(22, 6, 30, 1, 0, 0, 30, 1, 1, 16'h220c, 1, 0, 0, 2, 0);
        addEntry(23, 3, 22, 1, 22, 1, 0, 0, 9, 16'h230d, 0, 0, 1, 0, 0);

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            checkIdle();
        end
        rstN = 1'b1;
        // quiet outputs before the first instruction
        repeat (3) begin
            @(negedge clk);
            checkIdle();
        end

        while (doneCount < NUM_ENTRIES && cycle < TIMEOUT_CYCLES) begin
            stepCycle();
        end
        // drain last credits and writebacks
        repeat (8) begin
            stepCycle();
        end

        if (doneCount < NUM_ENTRIES) begin
            errors++;
            $display("Run timed out after %0d cycles with %0d instructions still pending",
                     cycle, NUM_ENTRIES - doneCount);
        end
        for (int w = 0; w < NUM_WARPS; w++) begin
            checks++;
            if (fetchCnt[w] != issuedCnt[w]) begin
                errors++;
                $display("Fail at %0t: fetchCredit[%0d] pulses expected %0d got %0d",
                         $time, w, issuedCnt[w], fetchCnt[w]);
            end
        end
        checks++;
        if (maxOutstanding != OC_CREDITS) begin
            errors++;
            $display("Operand-collector credit was never used up while returns were held back");
        end
        checks++;
        if (overlapIssued == 0) begin
            errors++;
            $display("No warp issued while another warp was waiting on a writeback");
        end

        $display("checks=%0d errors=%0d cycles=%0d", checks, errors, cycle);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- warpIssue.f
common/ibufPkg.sv
hdl/instrIngress.sv
ibuffer/warpBuffer.sv
ibuffer/issueArbiter.sv
hdl/ocEgress.sv
hdl/warpIssueTop.sv
tb/tbClock.sv
tb/warpIssueTb.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = warpIssueTb
FILELIST = warpIssue.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
